// File: Bender.yml
package:
  name: rvfi_tracer

sources:
  - trace_pkg.sv
  - retire_if.sv
  - trace_if.sv
  - trace_cfg_regs.sv
  - insn_classifier.sv
  - trace_buffer.sv
  - rvfi_tracer.sv
  - target: simulation
    files:
      - rvfi_tracer_props.sv
      - tb_rvfi_tracer.sv

// File: insn_classifier.sv
// ================================================
// Decodes each retired instruction into a class,
// access flags and display operand, stamps it with
// the cycle count and sends it on buffer credit.
// ================================================
`timescale 1ns/1ps
`default_nettype none

module insn_classifier #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  retire_if.sink                 retire,
  input  logic                   trace_en,
  input  trace_pkg::class_mask_t class_filter,
  trace_if.tx                    trace_out,
  output logic [15:0]            dropped_count
);
  import trace_pkg::*;

  localparam int unsigned CredW = $clog2(FIFO_DEPTH + 1);

  // SYSTEM funct12 codes with funct3 zero
  localparam logic [11:0] F12_ECALL  = 12'h000;
  localparam logic [11:0] F12_EBREAK = 12'h001;
  localparam logic [11:0] F12_MRET   = 12'h302;
  localparam logic [11:0] F12_DRET   = 12'h7b2;
  localparam logic [11:0] F12_WFI    = 12'h105;

  word_t       insn;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  insn_class_e cls;
  access_t     access;
  word_t       operand;
  word_t       imm_i;
  word_t       imm_s;
  word_t       imm_b;

  cycle_t           cycle_q;
  logic [CredW-1:0] credit_q;
  logic [15:0]      dropped_q;
  logic             valid_q;
  trace_rec_t       rec_q;
  logic             wanted;
  logic             send;

  assign insn   = retire.insn;
  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  always_comb begin
    cls = CLS_INVALID;
    if (insn[1:0] != 2'b11) begin
      cls = CLS_COMP;
    end else begin
      unique case (opcode)
        OPC_LUI, OPC_AUIPC: cls = CLS_U;
        OPC_JAL:            cls = CLS_J;
        OPC_JALR:           if (funct3 == 3'b000) cls = CLS_JALR;
        OPC_BRANCH:         if (funct3[2:1] != 2'b01) cls = CLS_B;
        OPC_LOAD: begin
          // lb, lh, lw, lbu, lhu
          if (funct3 != 3'b011 && funct3[2:1] != 2'b11) cls = CLS_LOAD;
        end
        OPC_STORE:          if (!funct3[2] && funct3[1:0] != 2'b11) cls = CLS_STORE;
        OPC_OP_IMM: begin
          if (funct3 == 3'b001) begin
            if (funct7 == 7'b0000000) cls = CLS_SHIFT;
          end else if (funct3 == 3'b101) begin
            if (funct7 == 7'b0000000 || funct7 == 7'b0100000) cls = CLS_SHIFT;
          end else begin
            cls = CLS_I;
          end
        end
        OPC_OP: begin
          // Base ops, sub/sra, and RV32M
          if (funct7 == 7'b0000000 || funct7 == 7'b0000001) begin
            cls = CLS_R;
          end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
            cls = CLS_R;
          end
        end
        OPC_MISC_MEM:       if (funct3[2:1] == 2'b00) cls = CLS_FENCE;
        OPC_SYSTEM: begin
          if (funct3 == 3'b000) begin
            if (insn[19:7] == '0 &&
                (insn[31:20] == F12_ECALL || insn[31:20] == F12_EBREAK ||
                 insn[31:20] == F12_MRET || insn[31:20] == F12_DRET ||
                 insn[31:20] == F12_WFI)) begin
              cls = CLS_SYS;
            end
          end else if (funct3 != 3'b100) begin
            cls = CLS_CSR;
          end
        end
        default: cls = CLS_INVALID;
      endcase
    end
  end

  // Access flags and display operand per class
  always_comb begin
    access  = '0;
    operand = '0;
    unique case (cls)
      CLS_R:     access = '{rs1: 1'b1, rs2: 1'b1, rd: 1'b1, mem: 1'b0};
      CLS_I, CLS_JALR: begin
        access  = '{rs1: 1'b1, rs2: 1'b0, rd: 1'b1, mem: 1'b0};
        operand = imm_i;
      end
      CLS_SHIFT: begin
        access  = '{rs1: 1'b1, rs2: 1'b0, rd: 1'b1, mem: 1'b0};
        operand = {27'b0, insn[24:20]};
      end
      CLS_U: begin
        access  = '{rs1: 1'b0, rs2: 1'b0, rd: 1'b1, mem: 1'b0};
        operand = {12'b0, insn[31:12]};
      end
      CLS_J: begin
        // Jump target comes straight from the next PC
        access  = '{rs1: 1'b0, rs2: 1'b0, rd: 1'b1, mem: 1'b0};
        operand = retire.pc_wdata;
      end
      CLS_B: begin
        access  = '{rs1: 1'b1, rs2: 1'b1, rd: 1'b0, mem: 1'b0};
        operand = retire.pc_rdata + imm_b;
      end
      CLS_LOAD: begin
        access  = '{rs1: 1'b1, rs2: 1'b0, rd: 1'b1, mem: 1'b1};
        operand = imm_i;
      end
      CLS_STORE: begin
        access  = '{rs1: 1'b1, rs2: 1'b1, rd: 1'b0, mem: 1'b1};
        operand = imm_s;
      end
      CLS_CSR: begin
        access  = '{rs1: !funct3[2], rs2: 1'b0, rd: 1'b1, mem: 1'b0};
        operand = {20'b0, insn[31:20]};
      end
      default: begin
        access  = '0;
        operand = '0;
      end
    endcase
  end

  assign wanted = retire.valid && trace_en && class_filter[cls];
  assign send   = wanted && (credit_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q   <= '0;
      credit_q  <= CredW'(FIFO_DEPTH);
      dropped_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      cycle_q <= cycle_q + 32'd1;
      valid_q <= send;
      unique case ({send, trace_out.credit})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
      // Saturating drop counter
      if (wanted && !send && dropped_q != 16'hffff) begin
        dropped_q <= dropped_q + 16'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (send) begin
      rec_q.cycle    <= cycle_q;
      rec_q.pc       <= retire.pc_rdata;
      rec_q.insn     <= insn;
      rec_q.cls      <= cls;
      rec_q.access   <= access;
      rec_q.operand  <= operand;
      rec_q.rd_wdata <= retire.rd_wdata;
      rec_q.mem_addr <= retire.mem_addr;
    end
  end

  assign trace_out.valid = valid_q;
  assign trace_out.rec   = rec_q;
  assign dropped_count   = dropped_q;

endmodule

`default_nettype wire

// File: retire_if.sv
// ================================================
// One retired instruction as seen on the core's
// RVFI port. Driven by the top level, read by the
// classifier. No back-pressure.
// ================================================
`timescale 1ns/1ps
`default_nettype none

interface retire_if;
  import trace_pkg::*;

  logic  valid;
  word_t insn;
  word_t pc_rdata;
  word_t pc_wdata;
  word_t rd_wdata;
  word_t mem_addr;

  modport source (
    output valid, insn, pc_rdata, pc_wdata, rd_wdata, mem_addr
  );

  modport sink (
    input valid, insn, pc_rdata, pc_wdata, rd_wdata, mem_addr
  );

endinterface

`default_nettype wire

// File: rvfi_tracer.sv
// ================================================
// Retirement trace unit, top level. Takes the RVFI
// retire port and a small config bus, and emits
// classified records on a credit-based stream.
// ================================================
`timescale 1ns/1ps
`default_nettype none

module rvfi_tracer #(
  parameter int unsigned FIFO_DEPTH  = 4,
  parameter int unsigned OUT_CREDITS = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rvfi_valid,
  input  trace_pkg::word_t       rvfi_insn,
  input  trace_pkg::word_t       rvfi_pc_rdata,
  input  trace_pkg::word_t       rvfi_pc_wdata,
  input  trace_pkg::word_t       rvfi_rd_wdata,
  input  trace_pkg::word_t       rvfi_mem_addr,
  input  logic                   cfg_we,
  input  logic                   cfg_addr,
  input  logic [15:0]            cfg_wdata,
  output logic [15:0]            cfg_rdata,
  input  logic                   trace_credit,
  output logic                   trace_valid,
  output trace_pkg::cycle_t      trace_cycle,
  output trace_pkg::word_t       trace_pc,
  output trace_pkg::word_t       trace_insn,
  output trace_pkg::insn_class_e trace_class,
  output trace_pkg::access_t     trace_access,
  output trace_pkg::word_t       trace_operand,
  output trace_pkg::word_t       trace_rd_wdata,
  output trace_pkg::word_t       trace_mem_addr,
  output logic [15:0]            dropped_count
);
  import trace_pkg::*;

  retire_if    retire_bus ();
  trace_if     trace_bus ();
  logic        trace_en;
  class_mask_t class_filter;
  trace_rec_t  out_rec;

  assign retire_bus.valid    = rvfi_valid;
  assign retire_bus.insn     = rvfi_insn;
  assign retire_bus.pc_rdata = rvfi_pc_rdata;
  assign retire_bus.pc_wdata = rvfi_pc_wdata;
  assign retire_bus.rd_wdata = rvfi_rd_wdata;
  assign retire_bus.mem_addr = rvfi_mem_addr;

  trace_cfg_regs u_cfg (
    .clk_i, .rst_ni, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
    .trace_en, .class_filter
  );

  insn_classifier #(.FIFO_DEPTH(FIFO_DEPTH)) u_classifier (
    .clk_i, .rst_ni, .retire(retire_bus.sink), .trace_en, .class_filter,
    .trace_out(trace_bus.tx), .dropped_count
  );

  trace_buffer #(.FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS)) u_buffer (
    .clk_i, .rst_ni, .trace_in(trace_bus.rx), .out_valid(trace_valid),
    .out_rec, .out_credit(trace_credit)
  );

  // Record fields onto the output ports
  assign trace_cycle    = out_rec.cycle;
  assign trace_pc       = out_rec.pc;
  assign trace_insn     = out_rec.insn;
  assign trace_class    = out_rec.cls;
  assign trace_access   = out_rec.access;
  assign trace_operand  = out_rec.operand;
  assign trace_rd_wdata = out_rec.rd_wdata;
  assign trace_mem_addr = out_rec.mem_addr;

endmodule

`default_nettype wire

// File: rvfi_tracer_props.sv
// ================================================
// Credit and reset properties of the trace buffer.
// Bound into every trace_buffer instance.
// ================================================
`timescale 1ns/1ps
`default_nettype none

module rvfi_tracer_props #(
  parameter int unsigned FIFO_DEPTH  = 4,
  parameter int unsigned OUT_CREDITS = 2
) (
  input logic                              clk_i,
  input logic                              rst_ni,
  input logic                              push,
  input logic                              out_valid,
  input logic [$clog2(FIFO_DEPTH + 1)-1:0] count,
  input logic                              out_credit
);

  localparam int unsigned CrdW = $clog2(OUT_CREDITS + 1);

  // Consumer credits seen at the output boundary
  logic [CrdW-1:0] crd_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crd_q <= CrdW'(OUT_CREDITS);
    end else begin
      crd_q <= crd_q + CrdW'(out_credit) - CrdW'(out_valid);
    end
  end

  // Classifier credits must keep the FIFO from overflowing
  no_push_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni) push |-> (count < FIFO_DEPTH)
  ) else $error("record pushed into a full trace FIFO");

  no_valid_without_credit: assert property (
    @(posedge clk_i) disable iff (!rst_ni) out_valid |-> (crd_q != '0)
  ) else $error("out_valid raised with no output credit");

  // First edge out of reset
  valid_low_after_reset: assert property (
    @(posedge clk_i) $rose(rst_ni) |-> !out_valid
  ) else $error("out_valid high right after reset");

endmodule

bind trace_buffer rvfi_tracer_props #(
  .FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS)
) u_props (
  .clk_i(clk_i), .rst_ni(rst_ni), .push(push), .out_valid(out_valid),
  .count(count_q), .out_credit(out_credit)
);

`default_nettype wire

// File: sim.f
trace_pkg.sv
retire_if.sv
trace_if.sv
trace_cfg_regs.sv
insn_classifier.sv
trace_buffer.sv
rvfi_tracer.sv
rvfi_tracer_props.sv
tb_rvfi_tracer.sv

// File: tb_rvfi_tracer.sv
// ================================================
// Directed testbench for the retire tracer. Drives
// RVFI retires and config writes, collects records
// and compares them with a reference decode.
// ================================================
`timescale 1ns/1ps
`default_nettype none

module tb_rvfi_tracer;
  import trace_pkg::*;

  logic        clk_i, rst_ni, rvfi_valid, cfg_we, cfg_addr, trace_credit;
  word_t       rvfi_insn, rvfi_pc_rdata, rvfi_pc_wdata, rvfi_rd_wdata, rvfi_mem_addr;
  logic [15:0] cfg_wdata, cfg_rdata, dropped_count;
  logic        trace_valid;
  cycle_t      trace_cycle;
  word_t       trace_pc, trace_insn, trace_operand, trace_rd_wdata, trace_mem_addr;
  insn_class_e trace_class;
  access_t     trace_access;

  integer      seed;
  int          errors, tests, failed, owed;
  bit          credit_hold;
  logic        en_m;
  class_mask_t filter_m;
  cycle_t      tb_cycle;
  trace_rec_t  got_rec;
  trace_rec_t  exp_q[$];
  trace_rec_t  rx_q[$];

  rvfi_tracer #(.FIFO_DEPTH(4), .OUT_CREDITS(2)) DUT (.*);

  always #4 clk_i = ~clk_i;

  // Mirror of the cycle stamp: 0 in the first cycle out of reset
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) tb_cycle <= '0;
    else tb_cycle <= tb_cycle + 32'd1;
  end

  assign got_rec = {trace_cycle, trace_pc, trace_insn, trace_class, trace_access,
                    trace_operand, trace_rd_wdata, trace_mem_addr};

  // Consumer collects records and returns one credit per record
  always @(negedge clk_i) begin
    if (rst_ni && trace_valid) begin
      rx_q.push_back(got_rec);
      owed++;
    end
    if (!credit_hold && owed > 0) begin
      trace_credit = 1'b1;
      owed--;
    end else begin
      trace_credit = 1'b0;
    end
  end

  function automatic trace_rec_t model_rec(input cycle_t cyc, input word_t insn,
      input word_t pc, input word_t npc, input word_t rdw, input word_t maddr);
    trace_rec_t r;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      immi;
    f3   = insn[14:12];
    f7   = insn[31:25];
    immi = {{20{insn[31]}}, insn[31:20]};
    r = {cyc, pc, insn, CLS_INVALID, 4'b0000, 32'd0, rdw, maddr};
    if (insn[1:0] != 2'b11) begin
      r.cls = CLS_COMP;
    end else begin
      case (insn[6:0])
        7'h37, 7'h17: r.cls = CLS_U;
        7'h6f: r.cls = CLS_J;
        7'h67: if (f3 == 3'd0) r.cls = CLS_JALR;
        7'h63: if (f3 != 3'd2 && f3 != 3'd3) r.cls = CLS_B;
        7'h03: if (f3 <= 3'd2 || f3 == 3'd4 || f3 == 3'd5) r.cls = CLS_LOAD;
        7'h23: if (f3 <= 3'd2) r.cls = CLS_STORE;
        7'h13: begin
          if (f3 == 3'd1) r.cls = (f7 == 7'h00) ? CLS_SHIFT : CLS_INVALID;
          else if (f3 == 3'd5) r.cls = (f7 == 7'h00 || f7 == 7'h20) ? CLS_SHIFT : CLS_INVALID;
          else r.cls = CLS_I;
        end
        7'h33: begin
          if (f7 == 7'h00 || f7 == 7'h01) r.cls = CLS_R;
          else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) r.cls = CLS_R;
        end
        7'h0f: if (f3 <= 3'd1) r.cls = CLS_FENCE;
        7'h73: begin
          if (f3 == 3'd0) begin
            case (insn[31:7])
              25'h0, {12'h001, 13'h0}, {12'h302, 13'h0}, {12'h7b2, 13'h0},
              {12'h105, 13'h0}: r.cls = CLS_SYS;
              default: r.cls = CLS_INVALID;
            endcase
          end else if (f3 != 3'd4) begin
            r.cls = CLS_CSR;
          end
        end
        default: r.cls = CLS_INVALID;
      endcase
    end
    // Access bits are rs1, rs2, rd, mem
    case (r.cls)
      CLS_R:    r.access = 4'b1110;
      CLS_I, CLS_JALR: begin
        r.access  = 4'b1010;
        r.operand = immi;
      end
      CLS_SHIFT: begin
        r.access  = 4'b1010;
        r.operand = {27'd0, insn[24:20]};
      end
      CLS_U: begin
        r.access  = 4'b0010;
        r.operand = {12'd0, insn[31:12]};
      end
      CLS_J: begin
        r.access  = 4'b0010;
        r.operand = npc;
      end
      CLS_B: begin
        r.access  = 4'b1100;
        r.operand = pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
      end
      CLS_LOAD: begin
        r.access  = 4'b1011;
        r.operand = immi;
      end
      CLS_STORE: begin
        r.access  = 4'b1101;
        r.operand = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      end
      CLS_CSR: begin
        r.access  = {~f3[2], 3'b010};
        r.operand = {20'd0, insn[31:20]};
      end
      default: r.access = 4'b0000;
    endcase
    return r;
  endfunction

  // Random instruction with the bits under fix_mask forced to fix_bits
  function automatic word_t pick(input word_t fix_mask, input word_t fix_bits);
    return ($random(seed) & ~fix_mask) | fix_bits;
  endfunction

  task automatic check_rec(input trace_rec_t got, input trace_rec_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED @%0t: record insn %h cls %0d/%0d operand %h/%h", $time,
               exp.insn, got.cls, exp.cls, got.operand, exp.operand);
      $display("  got %h", got);
      $display("  exp %h", exp);
    end
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED @%0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // One retire; back-to-back calls retire on consecutive edges
  task automatic issue(input word_t insn);
    trace_rec_t m;
    @(negedge clk_i);
    rvfi_valid    = 1'b1;
    rvfi_insn     = insn;
    rvfi_pc_rdata = $random(seed) & ~32'h3;
    rvfi_pc_wdata = $random(seed) & ~32'h1;
    rvfi_rd_wdata = $random(seed);
    rvfi_mem_addr = $random(seed);
    m = model_rec(tb_cycle, insn, rvfi_pc_rdata, rvfi_pc_wdata, rvfi_rd_wdata,
                  rvfi_mem_addr);
    if (en_m && filter_m[m.cls]) exp_q.push_back(m);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk_i);
      rvfi_valid = 1'b0;
    end
  endtask

  task automatic cfg_write(input logic addr, input logic [15:0] data);
    @(negedge clk_i);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk_i);
    cfg_we = 1'b0;
    if (addr == CFG_ADDR_CTRL) en_m = data[0];
    else filter_m = data;
  endtask

  task automatic cfg_expect(input logic addr, input logic [15:0] exp);
    @(negedge clk_i);
    cfg_addr = addr;
    @(negedge clk_i);
    check_word("cfg readback", word_t'(cfg_rdata), word_t'(exp));
  endtask

  task automatic wait_records(input int n);
    int cyc;
    cyc = 0;
    while (rx_q.size() < n && cyc < 100) begin
      @(posedge clk_i);
      cyc++;
    end
    if (rx_q.size() < n) begin
      $display("Timeout: only %0d of %0d records arrived by %0t", rx_q.size(), n, $time);
      $display("Done: errors found");
      $finish;
    end
  endtask

  task automatic drain_and_compare();
    wait_records(exp_q.size());
    repeat (6) @(posedge clk_i);
    check_count("record count", 16'(rx_q.size()), 16'(exp_q.size()));
    while (exp_q.size() > 0 && rx_q.size() > 0) begin
      check_rec(rx_q.pop_front(), exp_q.pop_front());
    end
    exp_q.delete();
    rx_q.delete();
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  task automatic test_reset_enable();
    int err0;
    err0 = errors;
    cfg_expect(CFG_ADDR_CTRL, 16'h0000);
    cfg_expect(CFG_ADDR_FILTER, 16'hffff);
    issue(pick(32'h0000707f, 32'h00000013));
    issue(pick(32'hfe00707f, 32'h00000033));
    idle(1);
    repeat (10) @(posedge clk_i);
    check_count("records while disabled", 16'(rx_q.size()), 16'd0);
    cfg_write(CFG_ADDR_CTRL, 16'h0001);
    cfg_expect(CFG_ADDR_CTRL, 16'h0001);
    issue(pick(32'h0000707f, 32'h00000013));
    idle(1);
    drain_and_compare();
    end_test("reset_enable", err0);
  endtask

  task automatic test_classes();
    int err0;
    err0 = errors;
    issue(pick(32'hfe00707f, 32'h00000033));
    issue(pick(32'hfe00707f, 32'h02000033));
    issue(pick(32'h0000707f, 32'h00004013));
    issue(pick(32'hfe00707f, 32'h40005013));
    issue(pick(32'h0000007f, 32'h00000037));
    issue(pick(32'h0000007f, 32'h00000017));
    issue(pick(32'h0000007f, 32'h0000006f));
    issue(pick(32'h0000707f, 32'h00000067));
    issue(pick(32'h0000707f, 32'h00005063));
    issue(pick(32'h0000707f, 32'h00004003));
    issue(pick(32'h0000707f, 32'h00001023));
    issue(pick(32'h0000707f, 32'h00002073));
    issue(pick(32'h0000707f, 32'h00005073));
    issue(32'h00100073);
    issue(32'h10500073);
    issue(pick(32'h0000707f, 32'h0000000f));
    issue(pick(32'h00000003, 32'h00000001));
    // Bad load size, then an RV32B andn
    issue(pick(32'h0000707f, 32'h00003003));
    issue(pick(32'hfe00707f, 32'h40007033));
    idle(1);
    drain_and_compare();
    end_test("classes", err0);
  endtask

  task automatic test_cycle_stamp();
    int err0;
    err0 = errors;
    repeat (8) begin
      issue(pick(32'h0000707f, 32'h00000013));
      idle(1 + ($random(seed) & 5));
    end
    drain_and_compare();
    end_test("cycle_stamp", err0);
  endtask

  task automatic test_filter();
    int err0;
    err0 = errors;
    cfg_write(CFG_ADDR_FILTER, 16'hfe7f);
    cfg_expect(CFG_ADDR_FILTER, 16'hfe7f);
    issue(pick(32'hfe00707f, 32'h00000033));
    issue(pick(32'h0000707f, 32'h00002003));
    issue(pick(32'h0000707f, 32'h00000013));
    issue(pick(32'h0000707f, 32'h00002023));
    issue(pick(32'h0000707f, 32'h00000063));
    issue(pick(32'h0000707f, 32'h00004003));
    issue(pick(32'h0000007f, 32'h00000037));
    idle(1);
    drain_and_compare();
    @(negedge clk_i);
    check_count("dropped_count", dropped_count, 16'd0);
    cfg_write(CFG_ADDR_FILTER, 16'hffff);
    end_test("filter", err0);
  endtask

  task automatic test_backpressure();
    int err0;
    err0 = errors;
    credit_hold = 1'b1;
    repeat (10) issue(pick(32'h0000707f, 32'h00000013));
    idle(1);
    wait_records(2);
    repeat (6) @(posedge clk_i);
    check_count("records without credit", 16'(rx_q.size()), 16'd2);
    @(negedge clk_i);
    check_count("dropped_count", dropped_count, 16'd4);
    // Last four retires find the buffer full
    repeat (4) void'(exp_q.pop_back());
    credit_hold = 1'b0;
    drain_and_compare();
    @(negedge clk_i);
    check_count("dropped_count", dropped_count, 16'd4);
    end_test("backpressure", err0);
  endtask

  initial begin
    seed          = 32'h4035_b761;
    errors        = 0;
    tests         = 0;
    failed        = 0;
    owed          = 0;
    credit_hold   = 1'b0;
    en_m          = 1'b0;
    filter_m      = 16'hffff;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    rvfi_valid    = 1'b0;
    rvfi_insn     = '0;
    rvfi_pc_rdata = '0;
    rvfi_pc_wdata = '0;
    rvfi_rd_wdata = '0;
    rvfi_mem_addr = '0;
    cfg_we        = 1'b0;
    cfg_addr      = 1'b0;
    cfg_wdata     = '0;
    trace_credit  = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    test_reset_enable();
    test_classes();
    test_cycle_stamp();
    test_filter();
    test_backpressure();

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: trace_buffer.sv
// ================================================
// Record FIFO between classifier and consumer.
// Returns an input credit per pop and emits only
// while it holds output credit.
// ================================================
`timescale 1ns/1ps
`default_nettype none

module trace_buffer #(
  parameter int unsigned FIFO_DEPTH  = 4,
  parameter int unsigned OUT_CREDITS = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  trace_if.rx                   trace_in,
  output logic                  out_valid,
  output trace_pkg::trace_rec_t out_rec,
  input  logic                  out_credit
);
  import trace_pkg::*;

  localparam int unsigned PtrW  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CntW  = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned OcrdW = $clog2(OUT_CREDITS + 1);

  trace_rec_t       mem [FIFO_DEPTH];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [CntW-1:0]  count_q;
  logic [OcrdW-1:0] out_crd_q;
  logic             credit_q;
  logic             push;
  logic             pop;

  assign push = trace_in.valid;
  assign pop  = (count_q != '0) && (out_crd_q != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= trace_in.rec;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      out_crd_q <= OcrdW'(OUT_CREDITS);
      credit_q  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(push) - CntW'(pop);
      // Consumer credit in, one spent per emitted record
      out_crd_q <= out_crd_q + OcrdW'(out_credit) - OcrdW'(pop);
      credit_q  <= pop;
    end
  end

  assign out_valid       = pop;
  assign out_rec         = mem[rd_ptr_q];
  assign trace_in.credit = credit_q;

endmodule

`default_nettype wire

// File: trace_cfg_regs.sv
// ================================================
// Trace configuration registers: global enable in
// CTRL bit 0 and the per-class record filter.
// Readback is combinational on the address.
// ================================================
`timescale 1ns/1ps
`default_nettype none

module trace_cfg_regs (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   cfg_we,
  input  logic                   cfg_addr,
  input  logic [15:0]            cfg_wdata,
  output logic [15:0]            cfg_rdata,
  output logic                   trace_en,
  output trace_pkg::class_mask_t class_filter
);
  import trace_pkg::*;

  // Only filter bits that map to a class are writable
  localparam int unsigned NumCls = int'(CLS_INVALID) + 1;

  logic              en_q;
  logic [NumCls-1:0] filter_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q     <= 1'b0;
      filter_q <= '1;
    end else if (cfg_we) begin
      if (cfg_addr == CFG_ADDR_CTRL) begin
        en_q <= cfg_wdata[0];
      end else begin
        filter_q <= cfg_wdata[NumCls-1:0];
      end
    end
  end

  // Unused class slots read back as set
  assign class_filter = {{($bits(class_mask_t) - NumCls){1'b1}}, filter_q};
  assign trace_en     = en_q;

  always_comb begin
    if (cfg_addr == CFG_ADDR_CTRL) begin
      cfg_rdata = {15'b0, en_q};
    end else begin
      cfg_rdata = class_filter;
    end
  end

endmodule

`default_nettype wire

// File: trace_if.sv
// ================================================
// Credit-based record stream from the classifier
// into the trace buffer. One credit pulse returns
// one buffer slot.
// ================================================
`timescale 1ns/1ps
`default_nettype none

interface trace_if;
  import trace_pkg::*;

  logic       valid;
  trace_rec_t rec;
  // Pulses once per entry leaving the buffer
  logic       credit;

  modport tx (
    output valid, rec,
    input  credit
  );

  modport rx (
    input  valid, rec,
    output credit
  );

endinterface

`default_nettype wire

// File: trace_pkg.sv
// ================================================
// Shared types and constants for the retire tracer.
// Imported by the classifier, buffer, config block,
// interfaces and testbench.
// ================================================
`default_nettype none

package trace_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] cycle_t;

  // Instruction format classes, also the bit index into the filter mask
  typedef enum logic [3:0] {
    CLS_R       = 4'd0,
    CLS_I       = 4'd1,
    CLS_SHIFT   = 4'd2,
    CLS_U       = 4'd3,
    CLS_J       = 4'd4,
    CLS_JALR    = 4'd5,
    CLS_B       = 4'd6,
    CLS_LOAD    = 4'd7,
    CLS_STORE   = 4'd8,
    CLS_CSR     = 4'd9,
    CLS_SYS     = 4'd10,
    CLS_FENCE   = 4'd11,
    CLS_COMP    = 4'd12,
    CLS_INVALID = 4'd13
  } insn_class_e;

  // Operands touched by the retired instruction
  typedef struct packed {
    logic rs1;
    logic rs2;
    logic rd;
    logic mem;
  } access_t;

  typedef struct packed {
    cycle_t      cycle;
    word_t       pc;
    word_t       insn;
    insn_class_e cls;
    access_t     access;
    word_t       operand;
    word_t       rd_wdata;
    word_t       mem_addr;
  } trace_rec_t;

  typedef logic [15:0] class_mask_t;

  // Major opcodes, insn[6:0]
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // Config register map
  localparam logic CFG_ADDR_CTRL   = 1'b0;
  localparam logic CFG_ADDR_FILTER = 1'b1;

endpackage

`default_nettype wire
